//--- Bender.yml
package:
  name: calc_control

sources:
  - files:
      - rtl/calc_mode_pkg.sv
      - rtl/calc_display_pkg.sv
      - rtl/button_debounce.sv
      - rtl/mode_sequencer.sv
      - rtl/error_countdown.sv
      - rtl/status_display.sv
      - rtl/calc_control_top.sv
  - target: test
    files:
      - bench/calc_control_props.sv
      - bench/calc_control_checker.sv
      - bench/calc_control_tb.sv

//--- bench/calc_control_checker.sv
// Response checker for the calculator control core
// Models the display and countdown rules, compares the DUT outputs
// and counts mismatches and other failures

`timescale 1ns/1ps

module calc_control_checker #(
    parameter int unsigned TICKS_PER_SECOND = 16
) (
    input logic                            clk,
    input logic                            rst_n,
    input calc_display_pkg::seg_t          seg_display,
    input calc_display_pkg::seg_t          seg_countdown,
    input calc_display_pkg::digit_select_t count_down_select,
    input logic [3:0]                      led_status,
    input logic                            error_timeout
);

    // Segments a..g in bits 0..6
    localparam logic [6:0] DIGIT_PAT [0:9] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };
    localparam logic [6:0] LETTER_E = 7'h79;

    int mismatch_count = 0;
    int failure_count  = 0;
    int cycle          = 0;
    int load_cycle     = 0;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Menu has no engine, so no error may ever show there
    always @(negedge clk) begin
        if (rst_n && led_status[2:0] == 3'd0 &&
            (led_status[3] || seg_display == LETTER_E)) begin
            report_failure("error indication shown while in the menu");
        end
    end

    task automatic compare_value(input string name, input logic [7:0] actual,
                                 input logic [7:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns",
                     name, actual, expected, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // ========================================
    // Scenario checks
    // ========================================
    task automatic check_idle(input int mode);
        @(negedge clk);
        compare_value("led_status", 8'(led_status), 8'(mode));
        compare_value("error_timeout", 8'(error_timeout), 8'h00);
        compare_value("seg_display", 8'(seg_display), 8'(DIGIT_PAT[mode]));
        compare_value("seg_countdown", 8'(seg_countdown), 8'h00);
    endtask

    task automatic compare_digit(input int value);
        if (count_down_select == 2'b10) begin
            compare_value("seg_countdown", 8'(seg_countdown), 8'(DIGIT_PAT[value / 10]));
        end else begin
            compare_value("seg_countdown", 8'(seg_countdown), 8'(DIGIT_PAT[value % 10]));
        end
    endtask

    // Two samples cover both select phases, which swap every cycle
    task automatic check_digits(input int value);
        logic [1:0] first_select;
        @(negedge clk);
        first_select = count_down_select;
        compare_digit(value);
        @(negedge clk);
        compare_value("count_down_select", 8'(count_down_select),
                      (first_select == 2'b01) ? 8'h02 : 8'h01);
        compare_digit(value);
    endtask

    task automatic wait_load(input int secs);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (led_status[3] !== 1'b1 && waited < 4);
        if (led_status[3] !== 1'b1) begin
            report_failure("error LED did not light within four cycles of raising error_code");
        end
        load_cycle = cycle;
        compare_value("seg_display", 8'(seg_display), 8'(LETTER_E));
        check_digits(secs);
    endtask

    task automatic wait_timeout(input int secs);
        int elapsed;
        elapsed = 0;
        do begin
            @(negedge clk);
            elapsed = cycle - load_cycle;
        end while (error_timeout !== 1'b1 && elapsed < secs * TICKS_PER_SECOND + 4);
        if (error_timeout !== 1'b1) begin
            report_failure("error_timeout did not rise after the countdown ran out");
        end else if (elapsed < (secs - 1) * TICKS_PER_SECOND) begin
            report_failure("error_timeout rose before the countdown ran out");
        end
        compare_value("error_led", 8'(led_status[3]), 8'h00);
        check_digits(0);
    endtask

    task automatic wait_clear(input int mode);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((seg_countdown !== 7'h00 || error_timeout !== 1'b0) && waited < 2);
        if (seg_countdown !== 7'h00 || error_timeout !== 1'b0) begin
            report_failure("countdown and timeout not cleared two cycles after dropping the error");
        end
        check_idle(mode);
    endtask

endmodule

//--- bench/calc_control_props.sv
// Control core assertions
// Bound into the top level to watch the select, error flags, mode and press pulses

`timescale 1ns/1ps

module calc_control_props (
    input logic       clk,
    input logic       rst_n,
    input logic       confirm_pulse,
    input logic       back_pulse,
    input logic [2:0] mode,
    input logic       error_led,
    input logic       error_timeout,
    input logic [1:0] count_down_select
);

    int violation_count = 0;

    select_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(count_down_select))
    else begin
        violation_count++;
        $error("count_down_select is not one-hot");
    end

    // LED goes dark in the same edge that raises the timeout
    timeout_led_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(error_timeout && error_led))
    else begin
        violation_count++;
        $error("error_timeout and error_led are high together");
    end

    mode_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        mode <= 3'd5)
    else begin
        violation_count++;
        $error("mode holds an undefined code");
    end

    confirm_single: assert property (@(posedge clk) disable iff (!rst_n)
        confirm_pulse |=> !confirm_pulse)
    else begin
        violation_count++;
        $error("confirm press pulse lasted more than one cycle");
    end

    back_single: assert property (@(posedge clk) disable iff (!rst_n)
        back_pulse |=> !back_pulse)
    else begin
        violation_count++;
        $error("back press pulse lasted more than one cycle");
    end

endmodule

bind calc_control_top calc_control_props u_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .confirm_pulse     (confirm_pulse),
    .back_pulse        (back_pulse),
    .mode              (mode),
    .error_led         (error_led),
    .error_timeout     (error_timeout),
    .count_down_select (count_down_select)
);

//--- bench/calc_control_tb.sv
// Testbench for the matrix calculator control core
// Applies a table of mode and error scenarios; the checker does the comparing

`timescale 1ns/1ps

module calc_control_tb;

    localparam int unsigned DEBOUNCE_CYCLES  = 4;
    localparam int unsigned TICKS_PER_SECOND = 16;
    localparam int          ROWS             = 10;
    localparam int          PRESS_CYCLES     = DEBOUNCE_CYCLES + 6;
    localparam int          WATCHDOG_CYCLES  =
        ROWS * ((int'(calc_mode_pkg::MAX_ERROR_SECONDS) + 2) * TICKS_PER_SECOND + 200);

    // Columns: switch code, error code, error_seconds, expected mode, expected loaded seconds
    // A non-zero error code outside the menu is replaced by a random one
    int stim [ROWS][5] = '{
        '{0, 3,  9, 0,  0},
        '{1, 1,  2, 1,  5},
        '{2, 1,  5, 2,  5},
        '{3, 1,  9, 3,  9},
        '{4, 1, 15, 4, 15},
        '{5, 1, 20, 5, 15},
        '{6, 2, 31, 0,  0},
        '{7, 0,  0, 0,  0},
        '{1, 1, 31, 1, 15},
        '{3, 0,  7, 3,  0}
    };

    logic                            clk;
    logic                            rst_n;
    calc_mode_pkg::sel_sw_t          dip_sw;
    logic                            btn_confirm;
    logic                            btn_back;
    calc_mode_pkg::err_code_t        error_code;
    calc_mode_pkg::seconds_t         error_seconds;
    calc_display_pkg::seg_t          seg_display;
    calc_display_pkg::seg_t          seg_countdown;
    calc_display_pkg::digit_select_t count_down_select;
    logic [3:0]                      led_status;
    logic                            error_timeout;
    int                              seed = 97023;

    calc_control_top #(
        .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) DUT (.*);

    calc_control_checker #(.TICKS_PER_SECOND(TICKS_PER_SECOND)) u_checker (.*);

    always #4 clk = ~clk;

    task automatic press_button(input logic use_confirm);
        @(posedge clk);
        #1;
        btn_confirm = use_confirm;
        btn_back    = !use_confirm;
        repeat (PRESS_CYCLES) @(posedge clk);
        #1;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        // Release has to settle through the debouncer too
        repeat (PRESS_CYCLES) @(posedge clk);
        #1;
    endtask

    task automatic apply_row(input int i);
        int exp_mode;
        int exp_load;
        int rand_value;
        exp_mode = stim[i][3];
        exp_load = stim[i][4];
        @(posedge clk);
        #1;
        dip_sw        = calc_mode_pkg::sel_sw_t'(stim[i][0]);
        error_seconds = calc_mode_pkg::seconds_t'(stim[i][2]);
        if (exp_mode == 0) begin
            error_code = calc_mode_pkg::err_code_t'(stim[i][1]);
        end
        press_button(1'b1);
        u_checker.check_idle(exp_mode);
        if (exp_load != 0) begin
            rand_value = $random(seed);
            if (rand_value[3:0] == 4'd0) begin
                rand_value = 1;
            end
            @(posedge clk);
            #1;
            error_code = calc_mode_pkg::err_code_t'(rand_value);
            u_checker.wait_load(exp_load);
            u_checker.wait_timeout(exp_load);
            @(posedge clk);
            #1;
            error_code = calc_mode_pkg::ERR_NONE;
            u_checker.wait_clear(exp_mode);
        end
        @(posedge clk);
        #1;
        error_code = calc_mode_pkg::ERR_NONE;
        if (exp_mode != 0) begin
            press_button(1'b0);
            u_checker.check_idle(0);
        end
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        dip_sw        = '0;
        btn_confirm   = 1'b0;
        btn_back      = 1'b0;
        error_code    = calc_mode_pkg::ERR_NONE;
        error_seconds = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        u_checker.check_idle(0);
        for (int i = 0; i < ROWS; i++) begin
            apply_row(i);
        end
        $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 u_checker.mismatch_count, u_checker.failure_count,
                 DUT.u_props.violation_count);
        if (u_checker.mismatch_count == 0 && u_checker.failure_count == 0 &&
            DUT.u_props.violation_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- flist.f
rtl/calc_mode_pkg.sv
rtl/calc_display_pkg.sv
rtl/button_debounce.sv
rtl/mode_sequencer.sv
rtl/error_countdown.sv
rtl/status_display.sv
rtl/calc_control_top.sv
bench/calc_control_props.sv
bench/calc_control_checker.sv
bench/calc_control_tb.sv

//--- rtl/button_debounce.sv
// Button debouncer
// Synchronizes a raw push button and emits one pulse per accepted press

`timescale 1ns/1ps

module button_debounce #(
    parameter int unsigned DEBOUNCE_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic btn_pulse
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic             sync_q0;
    logic             sync_q1;
    logic             level_q;
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q0    <= 1'b0;
            sync_q1    <= 1'b0;
            level_q    <= 1'b0;
            stable_cnt <= '0;
            btn_pulse  <= 1'b0;
        end else begin
            sync_q0   <= btn_in;
            sync_q1   <= sync_q0;
            btn_pulse <= 1'b0;
            if (sync_q1 == level_q) begin
                // Glitch back to the old level restarts the count
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                level_q    <= sync_q1;
                // Only the rising edge counts as a press
                btn_pulse  <= sync_q1;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/calc_control_top.sv
// Matrix calculator control core
// Button debounce, mode sequencing, error countdown and status display

`timescale 1ns/1ps

module calc_control_top #(
    parameter int unsigned DEBOUNCE_CYCLES  = calc_mode_pkg::DEFAULT_DEBOUNCE_CYCLES,
    parameter int unsigned TICKS_PER_SECOND = calc_mode_pkg::DEFAULT_TICKS_PER_SECOND
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  calc_mode_pkg::sel_sw_t          dip_sw,
    input  logic                            btn_confirm,
    input  logic                            btn_back,
    input  calc_mode_pkg::err_code_t        error_code,
    input  calc_mode_pkg::seconds_t         error_seconds,
    output calc_display_pkg::seg_t          seg_display,
    output calc_display_pkg::seg_t          seg_countdown,
    output calc_display_pkg::digit_select_t count_down_select,
    output logic [3:0]                      led_status,
    output logic                            error_timeout
);

    logic                      confirm_pulse;
    logic                      back_pulse;
    calc_mode_pkg::calc_mode_e mode;
    calc_mode_pkg::seconds_t   countdown;
    logic                      error_active;
    logic                      error_led;

    // ========================================
    // Decode
    // ========================================
    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_confirm (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_confirm),
        .btn_pulse (confirm_pulse)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db_back (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_back),
        .btn_pulse (back_pulse)
    );

    mode_sequencer u_mode_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .dip_sw        (dip_sw),
        .confirm_pulse (confirm_pulse),
        .back_pulse    (back_pulse),
        .mode          (mode)
    );

    // ========================================
    // Execute and result
    // ========================================
    error_countdown #(.TICKS_PER_SECOND(TICKS_PER_SECOND)) u_error_countdown (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .error_code    (error_code),
        .error_seconds (error_seconds),
        .countdown     (countdown),
        .error_active  (error_active),
        .error_led     (error_led),
        .error_timeout (error_timeout)
    );

    status_display u_status_display (
        .clk               (clk),
        .rst_n             (rst_n),
        .mode              (mode),
        .countdown         (countdown),
        .error_active      (error_active),
        .error_led         (error_led),
        .seg_display       (seg_display),
        .seg_countdown     (seg_countdown),
        .count_down_select (count_down_select),
        .led_status        (led_status)
    );

endmodule

//--- rtl/calc_display_pkg.sv
// Seven-segment display definitions
// Segment and digit types, digit select codes and segment patterns

package calc_display_pkg;

    // Active high, bit 0 is segment a up to bit 6 for segment g
    typedef logic [6:0] seg_t;
    typedef logic [3:0] digit_t;
    typedef logic [1:0] digit_select_t;

    localparam digit_select_t SEL_ONES = 2'b01;
    localparam digit_select_t SEL_TENS = 2'b10;

    // Patterns for digits 0 through 9
    localparam seg_t SEG_DIGITS [0:9] = '{
        7'h3F,
        7'h06,
        7'h5B,
        7'h4F,
        7'h66,
        7'h6D,
        7'h7D,
        7'h07,
        7'h7F,
        7'h6F
    };

    localparam seg_t SEG_E     = 7'h79;
    localparam seg_t SEG_BLANK = 7'h00;

endpackage

//--- rtl/calc_mode_pkg.sv
// Calculator mode definitions
// Mode encoding, error and countdown types, and timing defaults

package calc_mode_pkg;

    // Each mode value equals the switch code that selects it
    typedef enum logic [2:0] {
        MODE_MENU     = 3'd0,
        MODE_INPUT    = 3'd1,
        MODE_GENERATE = 3'd2,
        MODE_DISPLAY  = 3'd3,
        MODE_COMPUTE  = 3'd4,
        MODE_SETTING  = 3'd5
    } calc_mode_e;

    typedef logic [2:0] sel_sw_t;
    typedef logic [3:0] err_code_t;
    typedef logic [4:0] seconds_t;

    localparam err_code_t ERR_NONE = 4'd0;

    // Error countdown clamp bounds
    localparam seconds_t MIN_ERROR_SECONDS = 5'd5;
    localparam seconds_t MAX_ERROR_SECONDS = 5'd15;

    // Board defaults for a 100 MHz clock
    localparam int unsigned DEFAULT_TICKS_PER_SECOND = 100_000_000;
    localparam int unsigned DEFAULT_DEBOUNCE_CYCLES  = 2_000_000;

endpackage

//--- rtl/error_countdown.sv
// Error countdown timer
// Loads a clamped number of seconds on a new error, counts down
// once per second and flags a timeout at zero

`timescale 1ns/1ps

module error_countdown #(
    parameter int unsigned TICKS_PER_SECOND = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  calc_mode_pkg::calc_mode_e mode,
    input  calc_mode_pkg::err_code_t  error_code,
    input  calc_mode_pkg::seconds_t   error_seconds,
    output calc_mode_pkg::seconds_t   countdown,
    output logic                      error_active,
    output logic                      error_led,
    output logic                      error_timeout
);

    localparam int TICK_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

    logic                    error_live;
    calc_mode_pkg::seconds_t load_seconds;
    logic [TICK_W-1:0]       tick_cnt;

    // The menu has no engine behind it, so its error code is ignored
    assign error_live = (mode != calc_mode_pkg::MODE_MENU) &&
                        (error_code != calc_mode_pkg::ERR_NONE);

    always_comb begin
        if (error_seconds < calc_mode_pkg::MIN_ERROR_SECONDS) begin
            load_seconds = calc_mode_pkg::MIN_ERROR_SECONDS;
        end else if (error_seconds > calc_mode_pkg::MAX_ERROR_SECONDS) begin
            load_seconds = calc_mode_pkg::MAX_ERROR_SECONDS;
        end else begin
            load_seconds = error_seconds;
        end
    end

    // ========================================
    // Load, count down and timeout
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            countdown     <= '0;
            tick_cnt      <= '0;
            error_active  <= 1'b0;
            error_led     <= 1'b0;
            error_timeout <= 1'b0;
        end else if (!error_live) begin
            countdown     <= '0;
            tick_cnt      <= '0;
            error_active  <= 1'b0;
            error_led     <= 1'b0;
            error_timeout <= 1'b0;
        end else if (!error_active) begin
            // First live cycle of a new error
            countdown     <= load_seconds;
            tick_cnt      <= '0;
            error_active  <= 1'b1;
            error_led     <= 1'b1;
            error_timeout <= 1'b0;
        end else if (countdown == '0) begin
            error_timeout <= 1'b1;
            error_led     <= 1'b0;
        end else if (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1)) begin
            tick_cnt  <= '0;
            countdown <= countdown - 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/mode_sequencer.sv
// Calculator mode sequencer
// Main FSM that picks the active mode from the switches and buttons

`timescale 1ns/1ps

module mode_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  calc_mode_pkg::sel_sw_t  dip_sw,
    input  logic                    confirm_pulse,
    input  logic                    back_pulse,
    output calc_mode_pkg::calc_mode_e mode
);

    calc_mode_pkg::calc_mode_e mode_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= calc_mode_pkg::MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    always_comb begin
        mode_next = mode;
        if (mode == calc_mode_pkg::MODE_MENU) begin
            if (confirm_pulse) begin
                case (dip_sw)
                    3'd1, 3'd2, 3'd3, 3'd4, 3'd5: begin
                        mode_next = calc_mode_pkg::calc_mode_e'(dip_sw);
                    end
                    // Unused switch codes keep the menu
                    default: mode_next = calc_mode_pkg::MODE_MENU;
                endcase
            end
        end else begin
            // Confirm belongs to the mode itself, so only back matters here
            if (back_pulse) begin
                mode_next = calc_mode_pkg::MODE_MENU;
            end
        end
    end

endmodule

//--- rtl/status_display.sv
// Status display encoder
// Drives the mode digit, the multiplexed countdown digits and the LEDs

`timescale 1ns/1ps

module status_display (
    input  logic                            clk,
    input  logic                            rst_n,
    input  calc_mode_pkg::calc_mode_e       mode,
    input  calc_mode_pkg::seconds_t         countdown,
    input  logic                            error_active,
    input  logic                            error_led,
    output calc_display_pkg::seg_t          seg_display,
    output calc_display_pkg::seg_t          seg_countdown,
    output calc_display_pkg::digit_select_t count_down_select,
    output logic [3:0]                      led_status
);

    calc_mode_pkg::seconds_t  tens_full;
    calc_mode_pkg::seconds_t  ones_full;
    calc_display_pkg::digit_t tens_digit;
    calc_display_pkg::digit_t ones_digit;
    calc_display_pkg::digit_t shown_digit;

    // Alternate between the two countdown digits every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_down_select <= calc_display_pkg::SEL_ONES;
        end else if (count_down_select == calc_display_pkg::SEL_ONES) begin
            count_down_select <= calc_display_pkg::SEL_TENS;
        end else begin
            count_down_select <= calc_display_pkg::SEL_ONES;
        end
    end

    // Countdown never exceeds 31, so tens fits in one digit
    assign tens_full  = countdown / 5'd10;
    assign ones_full  = countdown % 5'd10;
    assign tens_digit = tens_full[3:0];
    assign ones_digit = ones_full[3:0];

    assign shown_digit = (count_down_select == calc_display_pkg::SEL_TENS) ?
                         tens_digit : ones_digit;

    assign seg_countdown = error_active ? calc_display_pkg::SEG_DIGITS[shown_digit] :
                                          calc_display_pkg::SEG_BLANK;

    // Letter E replaces the mode digit during an error
    assign seg_display = error_active ? calc_display_pkg::SEG_E :
                                        calc_display_pkg::SEG_DIGITS[mode];

    assign led_status = {error_led, mode};

endmodule
